// File: design/axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bridge import mb_test_pkg::*; (
    input  wire                   clk             , // system clock
    input  wire                   reset_i         , // sync, active high
    input  wire [AXI_ADDR_W-1:0]  s_axi_awaddr_i  ,
    input  wire                   s_axi_awvalid_i ,
    output logic                  s_axi_awready_o ,
    input  wire [AXI_DATA_W-1:0]  s_axi_wdata_i   ,
    input  wire [AXI_STRB_W-1:0]  s_axi_wstrb_i   ,
    input  wire                   s_axi_wvalid_i  ,
    output logic                  s_axi_wready_o  ,
    output logic [1:0]            s_axi_bresp_o   ,
    output logic                  s_axi_bvalid_o  ,
    input  wire                   s_axi_bready_i  ,
    input  wire [AXI_ADDR_W-1:0]  s_axi_araddr_i  ,
    input  wire                   s_axi_arvalid_i ,
    output logic                  s_axi_arready_o ,
    output logic [AXI_DATA_W-1:0] s_axi_rdata_o   ,
    output logic [1:0]            s_axi_rresp_o   ,
    output logic                  s_axi_rvalid_o  ,
    input  wire                   s_axi_rready_i  ,
    input  wire                   rx_evt_i        , // one pulse per received byte
    output logic [AXI_DATA_W-1:0] timer_period_o  , // register 0
    output logic [AXI_DATA_W-1:0] timer_width_o     // register 1
);

    logic [AXI_DATA_W-1:0] user_regs [REG_COUNT];                  // 0..6 rw, 7 rx count

    logic                  wr_fire;
    logic                  wr_hit;
    logic [REG_IDX_W-1:0]  wr_idx;
    logic                  rd_fire;
    logic                  rd_hit;
    logic [REG_IDX_W-1:0]  rd_idx;

    // address and data accepted together, one write outstanding
    assign wr_fire = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
    assign s_axi_awready_o = wr_fire;
    assign s_axi_wready_o  = wr_fire;
    assign wr_hit = (s_axi_awaddr_i[AXI_ADDR_W-1:REG_IDX_W+2] == '0);   // below 0x20
    assign wr_idx = s_axi_awaddr_i[REG_IDX_W+1:2];                      // byte offset ignored

    assign rd_fire = s_axi_arvalid_i && !s_axi_rvalid_o;
    assign s_axi_arready_o = rd_fire;
    assign rd_hit = (s_axi_araddr_i[AXI_ADDR_W-1:REG_IDX_W+2] == '0);
    assign rd_idx = s_axi_araddr_i[REG_IDX_W+1:2];

    assign timer_period_o = user_regs[REG_TIMER_PERIOD];
    assign timer_width_o  = user_regs[REG_TIMER_WIDTH];

    // register file, byte strobed writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                user_regs[i] <= '0;
            end
        end else begin
            if (wr_fire && wr_hit && wr_idx != REG_RX_COUNT) begin
                for (int b = 0; b < AXI_STRB_W; b++) begin
                    if (s_axi_wstrb_i[b]) begin
                        user_regs[wr_idx][8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
                    end
                end
            end
            if (rx_evt_i) begin
                user_regs[REG_RX_COUNT] <= user_regs[REG_RX_COUNT] + 1'b1;   // wraps
            end
        end
    end

    // write response channel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axi_bvalid_o <= 1'b0;
        end else if (wr_fire) begin
            s_axi_bvalid_o <= 1'b1;
        end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            s_axi_bresp_o <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // read data channel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axi_rvalid_o <= 1'b0;
        end else if (rd_fire) begin
            s_axi_rvalid_o <= 1'b1;
        end else if (s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axi_rdata_o <= rd_hit ? user_regs[rd_idx] : '0;     // zero on bad address
            s_axi_rresp_o <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // response held with its code until the master takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o));

    // an accepted write raises bvalid and blocks the next one
    a_no_aw_during_b: assert property (@(posedge clk) disable iff (reset_i)
        s_axi_awready_o |=> s_axi_bvalid_o && !s_axi_awready_o);

endmodule

`default_nettype wire

// File: design/mb_test_pkg.sv
`default_nettype none

package mb_test_pkg;

    // bus geometry
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;                    // one strobe per byte

    // user register map, index taken from address bits 4 to 2
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;
    localparam logic [REG_IDX_W-1:0] REG_TIMER_PERIOD = 3'd0;     // irq period in cycles
    localparam logic [REG_IDX_W-1:0] REG_TIMER_WIDTH  = 3'd1;     // irq pulse width in cycles
    localparam logic [REG_IDX_W-1:0] REG_RX_COUNT     = 3'd7;     // read only, received bytes

    // write and read response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // uart timing, uart shares the system clock
    localparam int unsigned CLK_FREQ_HZ   = 100_000_000;
    localparam int unsigned UART_BAUD     = 115_200;
    localparam int unsigned UART_BAUD_DIV = CLK_FREQ_HZ / UART_BAUD;   // 868 cycles per bit
    localparam int UART_DATA_W = 8;

    // counter widths shared by rx and tx
    localparam int UART_BAUD_CNT_W = $clog2(UART_BAUD_DIV);
    localparam int UART_BIT_CNT_W  = $clog2(UART_DATA_W + 2);     // start, data and stop

endpackage

`default_nettype wire

// File: design/mb_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module mb_test_top import mb_test_pkg::*; (
    input  wire                   clk             , // 100 MHz
    input  wire                   reset_i         , // sync, active high
    input  wire [AXI_ADDR_W-1:0]  s_axi_awaddr_i  ,
    input  wire                   s_axi_awvalid_i ,
    output wire                   s_axi_awready_o ,
    input  wire [AXI_DATA_W-1:0]  s_axi_wdata_i   ,
    input  wire [AXI_STRB_W-1:0]  s_axi_wstrb_i   ,
    input  wire                   s_axi_wvalid_i  ,
    output wire                   s_axi_wready_o  ,
    output wire [1:0]             s_axi_bresp_o   ,
    output wire                   s_axi_bvalid_o  ,
    input  wire                   s_axi_bready_i  ,
    input  wire [AXI_ADDR_W-1:0]  s_axi_araddr_i  ,
    input  wire                   s_axi_arvalid_i ,
    output wire                   s_axi_arready_o ,
    output wire [AXI_DATA_W-1:0]  s_axi_rdata_o   ,
    output wire [1:0]             s_axi_rresp_o   ,
    output wire                   s_axi_rvalid_o  ,
    input  wire                   s_axi_rready_i  ,
    input  wire                   uart_rx_i       ,
    output wire                   uart_tx_o       ,
    output wire                   irq_o
);

    wire                   rx_evt;                                 // loopback strobe
    wire [UART_DATA_W-1:0] rx_data;
    wire [AXI_DATA_W-1:0]  timer_period;
    wire [AXI_DATA_W-1:0]  timer_width;

    axi_bridge i_axi_bridge (
        .clk                ( clk               ),
        .reset_i            ( reset_i           ),
        .s_axi_awaddr_i     ( s_axi_awaddr_i    ),
        .s_axi_awvalid_i    ( s_axi_awvalid_i   ),
        .s_axi_awready_o    ( s_axi_awready_o   ),
        .s_axi_wdata_i      ( s_axi_wdata_i     ),
        .s_axi_wstrb_i      ( s_axi_wstrb_i     ),
        .s_axi_wvalid_i     ( s_axi_wvalid_i    ),
        .s_axi_wready_o     ( s_axi_wready_o    ),
        .s_axi_bresp_o      ( s_axi_bresp_o     ),
        .s_axi_bvalid_o     ( s_axi_bvalid_o    ),
        .s_axi_bready_i     ( s_axi_bready_i    ),
        .s_axi_araddr_i     ( s_axi_araddr_i    ),
        .s_axi_arvalid_i    ( s_axi_arvalid_i   ),
        .s_axi_arready_o    ( s_axi_arready_o   ),
        .s_axi_rdata_o      ( s_axi_rdata_o     ),
        .s_axi_rresp_o      ( s_axi_rresp_o     ),
        .s_axi_rvalid_o     ( s_axi_rvalid_o    ),
        .s_axi_rready_i     ( s_axi_rready_i    ),
        .rx_evt_i           ( rx_evt            ), // byte counter
        .timer_period_o     ( timer_period      ),
        .timer_width_o      ( timer_width       )
    );

    timer_interrupt i_timer_interrupt (
        .clk                ( clk               ),
        .reset_i            ( reset_i           ),
        .period_i           ( timer_period      ),
        .width_i            ( timer_width       ),
        .irq_o              ( irq_o             )
    );

    uart_rx i_uart_rx (
        .clk                ( clk               ),
        .reset_i            ( reset_i           ),
        .rx_i               ( uart_rx_i         ),
        .rx_evt_o           ( rx_evt            ),
        .rx_data_o          ( rx_data           )
    );

    // every received byte goes straight back out
    uart_tx i_uart_tx (
        .clk                ( clk               ),
        .reset_i            ( reset_i           ),
        .tx_evt_i           ( rx_evt            ),
        .tx_data_i          ( rx_data           ),
        .tx_o               ( uart_tx_o         ),
        .busy_o             (                   )  // not needed at line rate
    );

endmodule

`default_nettype wire

// File: design/timer_interrupt.sv
`timescale 1ns/1ps
`default_nettype none

module timer_interrupt import mb_test_pkg::*; (
    input  wire                   clk      , // system clock
    input  wire                   reset_i  , // sync, active high
    input  wire [AXI_DATA_W-1:0]  period_i , // cycles per interrupt, zero stops it
    input  wire [AXI_DATA_W-1:0]  width_i  , // pulse length in cycles
    output logic                  irq_o
);

    logic [AXI_DATA_W-1:0] cnt_q;
    logic [AXI_DATA_W-1:0] period_q;                               // taken at each wrap
    logic [AXI_DATA_W-1:0] width_q;
    logic                  wrap;

    // a stopped timer keeps reloading so a new period starts at once
    assign wrap = (period_q == '0) || (cnt_q == period_q - 1'b1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q    <= '0;
            period_q <= '0;
            width_q  <= '0;
            irq_o    <= 1'b0;
        end else begin
            if (wrap) begin
                cnt_q    <= '0;
                period_q <= period_i;
                width_q  <= (period_i == '0) ? '0 : width_i;       // no pulse while stopped
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            irq_o <= (cnt_q < width_q);                            // one cycle behind count
        end
    end

    a_irq_off_when_stopped: assert property (@(posedge clk) disable iff (reset_i)
        period_q == '0 |=> !irq_o);

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import mb_test_pkg::*; (
    input  wire                    clk       , // system clock
    input  wire                    reset_i   , // sync, active high
    input  wire                    rx_i      , // async serial line
    output logic                   rx_evt_o  , // one cycle per good byte
    output logic [UART_DATA_W-1:0] rx_data_o
);

    logic                       rx_meta;
    logic                       rx_sync;
    logic                       rx_prev;                           // for the falling edge
    logic                       busy;
    logic                       baud_tick;
    logic                       stop_bit;
    logic [UART_BAUD_CNT_W-1:0] baud_cnt;
    logic [UART_BIT_CNT_W-1:0]  bit_idx;                           // 0 start, then data, stop
    logic [UART_DATA_W-1:0]     shift_q;

    assign baud_tick = busy && (baud_cnt == '0);
    assign stop_bit  = (bit_idx == UART_BIT_CNT_W'(UART_DATA_W + 1));

    // two flop synchroniser, line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_evt_o <= 1'b0;
        end else begin
            rx_evt_o <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync) begin
                    busy     <= 1'b1;
                    baud_cnt <= UART_BAUD_CNT_W'(UART_BAUD_DIV / 2 - 1);   // land mid start bit
                    bit_idx  <= '0;
                end
            end else if (baud_tick) begin
                baud_cnt <= UART_BAUD_CNT_W'(UART_BAUD_DIV - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == '0 && rx_sync) begin
                    busy <= 1'b0;                                  // glitch, not a start bit
                end else if (stop_bit) begin
                    busy     <= 1'b0;
                    rx_evt_o <= rx_sync;                           // framing error drops byte
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (baud_tick && bit_idx != '0 && !stop_bit) begin
            shift_q <= {rx_sync, shift_q[UART_DATA_W-1:1]};
        end
        if (baud_tick && stop_bit && rx_sync) begin
            rx_data_o <= shift_q;
        end
    end

    a_evt_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        rx_evt_o |=> !rx_evt_o);

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import mb_test_pkg::*; (
    input  wire                    clk       , // system clock
    input  wire                    reset_i   , // sync, active high
    input  wire                    tx_evt_i  , // start a frame when idle
    input  wire [UART_DATA_W-1:0]  tx_data_i ,
    output logic                   tx_o      , // serial line
    output logic                   busy_o      // frame in flight
);

    logic [UART_DATA_W+1:0]     frame_q;                           // stop, data, start
    logic [UART_BAUD_CNT_W-1:0] baud_cnt;
    logic [UART_BIT_CNT_W-1:0]  bit_cnt;
    logic                       baud_tick;

    assign baud_tick = busy_o && (baud_cnt == '0);
    assign tx_o      = frame_q[0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frame_q  <= '1;                                        // line idle high
            busy_o   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tx_evt_i && !busy_o) begin
            frame_q  <= {1'b1, tx_data_i, 1'b0};
            busy_o   <= 1'b1;
            baud_cnt <= UART_BAUD_CNT_W'(UART_BAUD_DIV - 1);
            bit_cnt  <= '0;
        end else if (baud_tick) begin
            frame_q  <= {1'b1, frame_q[UART_DATA_W+1:1]};          // next bit, refill idle
            baud_cnt <= UART_BAUD_CNT_W'(UART_BAUD_DIV - 1);
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == UART_BIT_CNT_W'(UART_DATA_W + 1)) begin
                busy_o <= 1'b0;                                    // stop bit done
            end
        end else if (busy_o) begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // line back at idle once the stop bit has gone out
    a_idle_line_high: assert property (@(posedge clk) disable iff (reset_i)
        !busy_o |-> tx_o);

endmodule

`default_nettype wire

// File: mb_test.f
design/mb_test_pkg.sv
design/axi_bridge.sv
design/timer_interrupt.sv
design/uart_rx.sv
design/uart_tx.sv
design/mb_test_top.sv
testbench/tb_mb_test.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f mb_test.f \
    --top-module tb_mb_test \
    -Mdir obj_dir \
    -o sim_mb_test

./obj_dir/sim_mb_test | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without a failure"

// File: testbench/tb_mb_test.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mb_test import mb_test_pkg::*; ();

    localparam int FRAME_CYCLES = 10 * UART_BAUD_DIV;
    localparam int UART_WINDOW  = 14 * FRAME_CYCLES;               // nine frames, gaps, echo tail
    localparam int BUS_WINDOW   = 2000;
    localparam int TIMER_WINDOW = 1000;
    localparam int CYCLE_LIMIT  = 2 * (UART_WINDOW + BUS_WINDOW + TIMER_WINDOW);
    localparam int NUM_BYTES    = 8;

    logic                  clk;
    logic                  reset_i;
    logic [AXI_ADDR_W-1:0] s_axi_awaddr_i;
    logic                  s_axi_awvalid_i;
    wire                   s_axi_awready_o;
    logic [AXI_DATA_W-1:0] s_axi_wdata_i;
    logic [AXI_STRB_W-1:0] s_axi_wstrb_i;
    logic                  s_axi_wvalid_i;
    wire                   s_axi_wready_o;
    wire  [1:0]            s_axi_bresp_o;
    wire                   s_axi_bvalid_o;
    logic                  s_axi_bready_i;
    logic [AXI_ADDR_W-1:0] s_axi_araddr_i;
    logic                  s_axi_arvalid_i;
    wire                   s_axi_arready_o;
    wire  [AXI_DATA_W-1:0] s_axi_rdata_o;
    wire  [1:0]            s_axi_rresp_o;
    wire                   s_axi_rvalid_o;
    logic                  s_axi_rready_i;
    logic                  uart_rx_i;
    wire                   uart_tx_o;
    wire                   irq_o;

    logic [31:0] rand_state;
    logic [31:0] reg_model [REG_COUNT];                            // expected register contents
    logic [7:0]  sent_q [$];
    logic [7:0]  echo_q [$];                                       // bytes decoded from uart_tx_o
    logic        decoder_on = 1'b0;
    int          error_cnt = 0;
    int          test_cnt = 0;
    int          cycle_cnt = 0;

    mb_test_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    function automatic logic [31:0] apply_strobes(logic [31:0] old, logic [31:0] data,
                                                  logic [3:0] strb);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        $display("%-16s %s (%0d errors)", name,
                 (error_cnt == errs_before) ? "ok" : "FAILED", error_cnt - errs_before);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) begin
            reg_model[r] = '0;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int stall;
        stall = int'(next_random() % 4);
        @(negedge clk);
        s_axi_awaddr_i  = addr;
        s_axi_wdata_i   = data;
        s_axi_wstrb_i   = strb;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i  = 1'b1;
        @(posedge clk);                                             // bvalid low, accepted here
        if (!s_axi_awready_o || !s_axi_wready_o) begin
            report_error("awready and wready not raised together on a write");
        end
        @(negedge clk);
        while (!s_axi_bvalid_o) @(negedge clk);                     // response follows acceptance
        if (s_axi_awready_o || s_axi_wready_o) report_error("write accepted while bvalid high");
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        resp = s_axi_bresp_o;
        repeat (stall) begin
            @(negedge clk);
            if (!s_axi_bvalid_o) report_error("bvalid dropped before bready");
        end
        s_axi_bready_i = 1'b1;
        @(negedge clk);
        s_axi_bready_i = 1'b0;
        if (s_axi_bvalid_o) report_error("bvalid still high after bready");
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int stall;
        stall = int'(next_random() % 4);
        @(negedge clk);
        s_axi_araddr_i  = addr;
        s_axi_arvalid_i = 1'b1;
        @(posedge clk);                                             // rvalid low, accepted here
        if (!s_axi_arready_o) report_error("arready not raised on a read");
        @(negedge clk);
        while (!s_axi_rvalid_o) @(negedge clk);
        if (s_axi_arready_o) report_error("read accepted while rvalid high");
        s_axi_arvalid_i = 1'b0;
        data = s_axi_rdata_o;
        resp = s_axi_rresp_o;
        repeat (stall) begin                                        // rready held low
            @(negedge clk);
            if (!s_axi_rvalid_o || s_axi_rdata_o !== data) begin
                report_error("read data not held while rready was low");
            end
        end
        s_axi_rready_i = 1'b1;
        @(negedge clk);
        s_axi_rready_i = 1'b0;
        if (s_axi_rvalid_o) report_error("rvalid still high after rready");
    endtask

    task automatic check_read(input logic [2:0] idx);
        logic [31:0] rdata;
        logic [1:0]  resp;
        bus_read({27'd0, idx, 2'(next_random())}, rdata, resp);     // low bits are don't care
        if (resp !== RESP_OKAY) begin
            report_error($sformatf("reg %0d read response %0b, expected OKAY", idx, resp));
        end
        if (rdata !== reg_model[idx]) begin
            report_error($sformatf("reg %0d read %08h, expected %08h", idx, rdata,
                                   reg_model[idx]));
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_val);
        @(negedge clk);
        uart_rx_i = 1'b0;                                           // start bit
        repeat (UART_BAUD_DIV) @(negedge clk);
        for (int i = 0; i < UART_DATA_W; i++) begin
            uart_rx_i = data[i];
            repeat (UART_BAUD_DIV) @(negedge clk);
        end
        uart_rx_i = stop_val;
        repeat (UART_BAUD_DIV) @(negedge clk);
        uart_rx_i = 1'b1;
    endtask

    // serial decoder on the echo line, samples each bit in its middle
    initial begin : echo_decoder
        logic       prev_line;
        logic [7:0] data;
        prev_line = 1'b1;
        wait (decoder_on);
        forever begin
            @(negedge clk);
            if (prev_line && !uart_tx_o) begin
                repeat (UART_BAUD_DIV / 2) @(negedge clk);
                if (uart_tx_o !== 1'b0) report_error("echo start bit not low at mid-bit");
                for (int i = 0; i < UART_DATA_W; i++) begin
                    repeat (UART_BAUD_DIV) @(negedge clk);
                    data[i] = uart_tx_o;
                end
                repeat (UART_BAUD_DIV) @(negedge clk);
                if (uart_tx_o !== 1'b1) report_error("echo stop bit not high");
                echo_q.push_back(data);
            end
            prev_line = uart_tx_o;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [3:0]  strb;
        logic [2:0]  idx;
        logic [1:0]  resp;
        int          errs;
        int          period;
        int          width;
        int          high_len;
        int          rise_gap;
        reset_i         = 1'b1;
        s_axi_awaddr_i  = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b0;
        s_axi_araddr_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        uart_rx_i       = 1'b1;                                     // line idle
        rand_state      = 32'd39;
        apply_reset();
        decoder_on = 1'b1;

        errs = error_cnt;
        for (int n = 0; n < 24; n++) begin
            idx  = 3'(next_random() % 7);
            addr = {27'd0, idx, 2'(next_random())};
            data = next_random();
            strb = 4'(next_random());
            bus_write(addr, data, strb, resp);
            if (resp !== RESP_OKAY) report_error($sformatf("write response %0b", resp));
            reg_model[idx] = apply_strobes(reg_model[idx], data, strb);
            check_read(3'(next_random() % 7));
        end
        for (int r = 0; r < REG_COUNT; r++) check_read(3'(r));
        finish_test("register_rw", errs);

        errs = error_cnt;
        for (int n = 0; n < 6; n++) begin
            addr = next_random();
            if (addr < 32'h20) addr = addr + 32'h20;
            bus_write(addr, next_random(), 4'hf, resp);
            if (resp !== RESP_SLVERR) report_error($sformatf("bad write response %0b", resp));
            bus_read(addr, rdata, resp);
            if (resp !== RESP_SLVERR) report_error($sformatf("bad read response %0b", resp));
            if (rdata !== '0) report_error($sformatf("bad read data %08h", rdata));
        end
        bus_write(32'h1C, next_random(), 4'hf, resp);               // rx count is read only
        if (resp !== RESP_OKAY) report_error($sformatf("reg 7 write response %0b", resp));
        for (int r = 0; r < REG_COUNT; r++) check_read(3'(r));
        finish_test("bad_address", errs);

        errs = error_cnt;
        for (int n = 0; n < NUM_BYTES; n++) begin
            data = next_random();
            sent_q.push_back(data[7:0]);
            send_frame(data[7:0], 1'b1);
            reg_model[REG_RX_COUNT] = reg_model[REG_RX_COUNT] + 1;
            repeat (UART_BAUD_DIV * (1 + next_random() % 3)) @(negedge clk);
        end
        while (echo_q.size() < sent_q.size()) @(negedge clk);
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (echo_q[i] !== sent_q[i]) begin
                report_error($sformatf("echo byte %0d is %02h, expected %02h", i, echo_q[i],
                                       sent_q[i]));
            end
        end
        finish_test("uart_loopback", errs);

        errs = error_cnt;
        echo_q.delete();
        send_frame(8'(next_random()), 1'b0);                        // framing error
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        if (echo_q.size() != 0) report_error("frame with a bad stop bit was echoed");
        check_read(REG_RX_COUNT);
        finish_test("rx_count", errs);

        apply_reset();                                              // old period may be huge
        errs = error_cnt;
        period = 4 + int'(next_random() % 13);
        width  = 1 + int'(next_random() % (period - 1));
        bus_write(32'h0, 32'(period), 4'hf, resp);
        bus_write(32'h4, 32'(width), 4'hf, resp);
        reg_model[REG_TIMER_PERIOD] = 32'(period);
        reg_model[REG_TIMER_WIDTH]  = 32'(width);
        check_read(REG_TIMER_PERIOD);
        check_read(REG_TIMER_WIDTH);
        while (irq_o) @(negedge clk);
        while (!irq_o) @(negedge clk);
        for (int p = 0; p < 4; p++) begin
            high_len = 0;
            while (irq_o) begin
                high_len++;
                @(negedge clk);
            end
            rise_gap = high_len;
            while (!irq_o) begin
                rise_gap++;
                @(negedge clk);
            end
            if (high_len != width) begin
                report_error($sformatf("irq high for %0d cycles, expected %0d", high_len, width));
            end
            if (rise_gap != period) begin
                report_error($sformatf("irq rises %0d cycles apart, expected %0d", rise_gap,
                                       period));
            end
        end
        bus_write(32'h0, 32'h0, 4'hf, resp);
        repeat (period + 2) @(negedge clk);                         // stops at the next wrap
        for (int c = 0; c < 3 * period; c++) begin
            @(negedge clk);
            if (irq_o) report_error("irq high after the period was set to zero");
        end
        finish_test("timer_irq", errs);

        $display("tests run: %0d, errors: %0d", test_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
